/* hw/bram_simple_dual_port.sv */
`timescale 1ns/1ns

// simple dual port block RAM
// port A writes, port B reads with one cycle of latency
module bram_simple_dual_port import fifo_pkg::*;
(
    input  logic                  clk,

    // write port
    input  logic                  wen_a,
    input  logic [ADDR_W-1:0]     addr_a,
    input  logic [FIFO_WIDTH-1:0] din_a,

    // read port
    input  logic                  ren_b,
    input  logic [ADDR_W-1:0]     addr_b,
    output logic [FIFO_WIDTH-1:0] dout_b
);

    logic [FIFO_WIDTH-1:0] mem [FIFO_DEPTH];

    always_ff @(posedge clk)
    begin
        if (wen_a)
        begin
            mem[addr_a] <= din_a;
        end
    end

    // output register only moves on a read enable
    always_ff @(posedge clk)
    begin
        if (ren_b)
        begin
            dout_b <= mem[addr_b];
        end
    end

endmodule

/* hw/fifo_based_on_ram.sv */
`timescale 1ns/1ns

// FWFT FIFO controller in front of a block RAM
//
// words leave the RAM through a two-entry prefetch stage; the head of
// that stage is fifo_dout. a RAM read is issued whenever the stage
// still has room once the read in flight has landed.
module fifo_based_on_ram import fifo_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // fifo write side
    input  logic                  fifo_wen,
    input  logic [FIFO_WIDTH-1:0] fifo_din,

    // fifo read side
    input  logic                  fifo_ren,
    output logic [FIFO_WIDTH-1:0] fifo_dout,

    input  thresh_t               thresh,
    output fifo_status_t          status,

    // RAM ports
    output logic                  ram_wen,
    output logic [ADDR_W-1:0]     ram_w_addr,
    output logic [FIFO_WIDTH-1:0] ram_din,
    output logic                  ram_ren,
    output logic [ADDR_W-1:0]     ram_r_addr,
    input  logic [FIFO_WIDTH-1:0] ram_dout
);

    logic [CNT_W-1:0]      wptr_q;  // top bit is the wrap bit
    logic [CNT_W-1:0]      rptr_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [CNT_W-1:0]      cnt_next;
    logic                  full_q;
    logic                  almost_full_q;
    logic                  almost_empty_q;

    pf_state_e             pf_state_q;
    pf_state_e             pf_state_d;
    logic [FIFO_WIDTH-1:0] head_q;
    logic [FIFO_WIDTH-1:0] head_d;
    logic [FIFO_WIDTH-1:0] tail_q;
    logic [FIFO_WIDTH-1:0] tail_d;
    logic                  inflight_q;  // ram_dout valid this cycle

    logic                  empty;
    logic                  wr_acc;
    logic                  rd_acc;
    logic                  ram_has_data;
    logic [1:0]            pf_cnt;
    logic [2:0]            occ_after_rd;

    assign empty  = (pf_state_q == PF_EMPTY);
    assign wr_acc = fifo_wen && !full_q;   // writes when full are dropped
    assign rd_acc = fifo_ren && !empty;    // reads when empty are dropped

    // words still sitting in the RAM, not yet read out
    assign ram_has_data = (wptr_q != rptr_q);

    always_comb
    begin
        case (pf_state_q)
            PF_EMPTY: pf_cnt = 2'd0;
            PF_ONE:   pf_cnt = 2'd1;
            PF_TWO:   pf_cnt = 2'd2;
            default:  pf_cnt = 2'd0;
        endcase
    end

    // stage occupancy on the next edge, before any new read lands
    assign occ_after_rd = 3'(pf_cnt) + 3'(inflight_q) - 3'(rd_acc);

    assign ram_wen    = wr_acc;
    assign ram_w_addr = wptr_q[ADDR_W-1:0];
    assign ram_din    = fifo_din;
    assign ram_ren    = ram_has_data && (occ_after_rd <= 3'd1);
    assign ram_r_addr = rptr_q[ADDR_W-1:0];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wptr_q     <= '0;
            rptr_q     <= '0;
            inflight_q <= 1'b0;
        end
        else
        begin
            if (wr_acc)
            begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (ram_ren)
            begin
                rptr_q <= rptr_q + 1'b1;
            end
            inflight_q <= ram_ren;
        end
    end

    // prefetch stage next state and contents
    always_comb
    begin
        pf_state_d = pf_state_q;
        head_d     = head_q;
        tail_d     = tail_q;
        case (pf_state_q)
            PF_EMPTY:
            begin
                if (inflight_q)
                begin
                    head_d     = ram_dout;
                    pf_state_d = PF_ONE;
                end
            end
            PF_ONE:
            begin
                if (rd_acc && inflight_q)
                begin
                    head_d = ram_dout;  // arriving word replaces the consumed head
                end
                else if (rd_acc)
                begin
                    pf_state_d = PF_EMPTY;
                end
                else if (inflight_q)
                begin
                    tail_d     = ram_dout;
                    pf_state_d = PF_TWO;
                end
            end
            PF_TWO:
            begin
                // issue rule keeps the RAM idle here
                if (rd_acc)
                begin
                    head_d     = tail_q;
                    pf_state_d = PF_ONE;
                end
            end
            default:
            begin
                pf_state_d = PF_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pf_state_q <= PF_EMPTY;
        end
        else
        begin
            pf_state_q <= pf_state_d;
        end
    end

    always_ff @(posedge clk)
    begin
        head_q <= head_d;
        tail_q <= tail_d;
    end

    assign fifo_dout = head_q;

    // total count covers RAM, read in flight and prefetch stage
    assign cnt_next = cnt_q + CNT_W'(wr_acc) - CNT_W'(rd_acc);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cnt_q          <= '0;
            full_q         <= 1'b0;
            almost_full_q  <= 1'b0;
            almost_empty_q <= 1'b1;
        end
        else
        begin
            cnt_q          <= cnt_next;
            full_q         <= (cnt_next == CNT_W'(FIFO_DEPTH));
            almost_full_q  <= (cnt_next >= thresh.almost_full_th);
            almost_empty_q <= (cnt_next <= thresh.almost_empty_th);
        end
    end

    assign status = '{
        full:         full_q,
        full_n:       ~full_q,
        almost_full:  almost_full_q,
        empty:        empty,
        almost_empty: almost_empty_q,
        data_cnt:     cnt_q
    };

endmodule

/* hw/fifo_pkg.sv */
package fifo_pkg;

    // storage geometry
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_WIDTH = 32;
    localparam int ADDR_W     = 4;
    localparam int CNT_W      = 5;  // must hold FIFO_DEPTH itself

    // threshold values after reset
    localparam int AF_TH_RST = 12;
    localparam int AE_TH_RST = 3;

    // which threshold register a config access targets
    typedef enum logic [0:0] {
        SEL_AF_TH = 1'b0,
        SEL_AE_TH = 1'b1
    } thresh_sel_e;

    // fill level of the two-word prefetch stage
    typedef enum logic [1:0] {
        PF_EMPTY = 2'd0,
        PF_ONE   = 2'd1,
        PF_TWO   = 2'd2
    } pf_state_e;

    typedef struct packed {
        logic             wen;
        thresh_sel_e      sel;
        logic [CNT_W-1:0] data;
    } cfg_wr_t;

    typedef struct packed {
        logic [CNT_W-1:0] almost_full_th;
        logic [CNT_W-1:0] almost_empty_th;
    } thresh_t;

    typedef struct packed {
        logic             full;
        logic             full_n;
        logic             almost_full;
        logic             empty;
        logic             almost_empty;
        logic [CNT_W-1:0] data_cnt;
    } fifo_status_t;

endpackage

/* hw/fifo_thresh_regs.sv */
`timescale 1ns/1ns

// run-time almost full / almost empty thresholds
// written values are forced into 1 .. FIFO_DEPTH-1
module fifo_thresh_regs import fifo_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,

    input  cfg_wr_t          cfg,
    output logic [CNT_W-1:0] cfg_rdata,

    output thresh_t          thresh
);

    logic [CNT_W-1:0] af_th_q;
    logic [CNT_W-1:0] ae_th_q;
    logic [CNT_W-1:0] wr_val;

    // keep a threshold away from 0 and FIFO_DEPTH
    function automatic logic [CNT_W-1:0] clamp_th(input logic [CNT_W-1:0] val);
        logic [CNT_W-1:0] res;
        if (val == '0)
        begin
            res = CNT_W'(1);
        end
        else if (val >= CNT_W'(FIFO_DEPTH))
        begin
            res = CNT_W'(FIFO_DEPTH - 1);
        end
        else
        begin
            res = val;
        end
        return res;
    endfunction

    assign wr_val = clamp_th(cfg.data);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            af_th_q <= CNT_W'(AF_TH_RST);
            ae_th_q <= CNT_W'(AE_TH_RST);
        end
        else if (cfg.wen)
        begin
            if (cfg.sel == SEL_AF_TH)
            begin
                af_th_q <= wr_val;
            end
            else
            begin
                ae_th_q <= wr_val;
            end
        end
    end

    // readback follows sel directly, no wen needed
    always_comb
    begin
        case (cfg.sel)
            SEL_AF_TH: cfg_rdata = af_th_q;
            SEL_AE_TH: cfg_rdata = ae_th_q;
            default:   cfg_rdata = af_th_q;
        endcase
    end

    assign thresh.almost_full_th  = af_th_q;
    assign thresh.almost_empty_th = ae_th_q;

endmodule

/* hw/ram_fifo_wrapper.sv */
`timescale 1ns/1ns

// top level: threshold registers, FIFO controller and block RAM
module ram_fifo_wrapper import fifo_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  fifo_wen,
    input  logic [FIFO_WIDTH-1:0] fifo_din,
    input  logic                  fifo_ren,
    output logic [FIFO_WIDTH-1:0] fifo_dout,
    output fifo_status_t          status,

    // threshold configuration
    input  cfg_wr_t               cfg,
    output logic [CNT_W-1:0]      cfg_rdata
);

    thresh_t               thresh;

    logic                  ram_wen;
    logic [ADDR_W-1:0]     ram_w_addr;
    logic [FIFO_WIDTH-1:0] ram_din;
    logic                  ram_ren;
    logic [ADDR_W-1:0]     ram_r_addr;
    logic [FIFO_WIDTH-1:0] ram_dout;

    fifo_thresh_regs u_thresh_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .cfg_rdata (cfg_rdata),
        .thresh    (thresh)
    );

    fifo_based_on_ram u_fifo_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .fifo_wen   (fifo_wen),
        .fifo_din   (fifo_din),
        .fifo_ren   (fifo_ren),
        .fifo_dout  (fifo_dout),
        .thresh     (thresh),
        .status     (status),
        .ram_wen    (ram_wen),
        .ram_w_addr (ram_w_addr),
        .ram_din    (ram_din),
        .ram_ren    (ram_ren),
        .ram_r_addr (ram_r_addr),
        .ram_dout   (ram_dout)
    );

    bram_simple_dual_port u_fifo_ram (
        .clk    (clk),
        .wen_a  (ram_wen),
        .addr_a (ram_w_addr),
        .din_a  (ram_din),
        .ren_b  (ram_ren),
        .addr_b (ram_r_addr),
        .dout_b (ram_dout)
    );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fifo -f tb.f -o sim_tb_fifo

out=$(./obj_dir/sim_tb_fifo)
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

/* tb.f */
hw/fifo_pkg.sv
hw/bram_simple_dual_port.sv
hw/fifo_thresh_regs.sv
hw/fifo_based_on_ram.sv
hw/ram_fifo_wrapper.sv
tb/fifo_assertions.sv
tb/tb_fifo.sv

/* tb/fifo_assertions.sv */
`timescale 1ns/1ns

// status invariants bound into the top level
module fifo_assertions import fifo_pkg::*;
(
    input logic         clk,
    input logic         arst_n,
    input logic         fifo_wen,
    input logic         fifo_ren,
    input fifo_status_t status
);

    int err_cnt = 0;  // number of failed assertions

    full_empty_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(status.full && status.empty)
    )
    else
    begin
        $error("full and empty are high together");
        err_cnt++;
    end

    count_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        status.data_cnt <= CNT_W'(FIFO_DEPTH)
    )
    else
    begin
        $error("data_cnt is above the FIFO depth");
        err_cnt++;
    end

    full_n_inverse: assert property (
        @(posedge clk) disable iff (!arst_n)
        status.full_n == !status.full
    )
    else
    begin
        $error("full_n is not the inverse of full");
        err_cnt++;
    end

    // a lone write into a full FIFO must be dropped
    write_when_full_dropped: assert property (
        @(posedge clk) disable iff (!arst_n)
        (fifo_wen && !fifo_ren && status.full) |=> $stable(status.data_cnt)
    )
    else
    begin
        $error("write while full changed data_cnt");
        err_cnt++;
    end

endmodule

/* tb/tb_fifo.sv */
`timescale 1ns/1ns

module tb_fifo import fifo_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int N_MIXED    = 40;
    // strobe cycles per test that size the watchdog
    localparam int T1_STROBES = 6;
    localparam int T2_STROBES = 8;
    localparam int T3_STROBES = 40;
    localparam int T4_STROBES = 2 * N_MIXED + 2 * FIFO_DEPTH;
    localparam int T5_STROBES = 12 + FIFO_DEPTH + 2 * FIFO_DEPTH;
    localparam int WATCHDOG_NS = (T1_STROBES + T2_STROBES + T3_STROBES + T4_STROBES
                                  + T5_STROBES) * CLK_PERIOD * 2 + 400;

    logic                  clk;
    logic                  arst_n;
    logic                  fifo_wen;
    logic [FIFO_WIDTH-1:0] fifo_din;
    logic                  fifo_ren;
    logic [FIFO_WIDTH-1:0] fifo_dout;
    fifo_status_t          status;
    cfg_wr_t               cfg;
    logic [CNT_W-1:0]      cfg_rdata;

    logic [FIFO_WIDTH-1:0] model_q [$];  // expected contents with the oldest first
    logic [CNT_W-1:0]      af_sh;
    logic [CNT_W-1:0]      ae_sh;
    logic [CNT_W-1:0]      af_used;      // threshold the flags were computed with
    logic [CNT_W-1:0]      ae_used;
    bit                    wr_ok;
    bit                    rd_ok;
    bit                    chk_en;
    int                    seed = 25477;
    int                    test_errs;
    int                    assert_seen;  // bound assertion failures already charged
    int                    pass_cnt;
    int                    fail_cnt;
    string                 cur_test;

    ram_fifo_wrapper DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .fifo_wen  (fifo_wen),
        .fifo_din  (fifo_din),
        .fifo_ren  (fifo_ren),
        .fifo_dout (fifo_dout),
        .status    (status),
        .cfg       (cfg),
        .cfg_rdata (cfg_rdata)
    );

    bind ram_fifo_wrapper fifo_assertions u_assertions (
        .clk      (clk),
        .arst_n   (arst_n),
        .fifo_wen (fifo_wen),
        .fifo_ren (fifo_ren),
        .status   (status)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish in time");
        $display("tests failed");
        $finish;
    end

    // thresholds are held inside 1 .. FIFO_DEPTH-1
    function automatic logic [CNT_W-1:0] expected_clamp(input int val);
        if (val < 1)
            return CNT_W'(1);
        if (val > FIFO_DEPTH - 1)
            return CNT_W'(FIFO_DEPTH - 1);
        return CNT_W'(val);
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else
        begin
            $display("ERROR %s %s expected %0h actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    // reference model updated from the strobes the DUT samples on this edge
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            model_q.delete();
            af_sh   = CNT_W'(AF_TH_RST);
            ae_sh   = CNT_W'(AE_TH_RST);
            af_used = af_sh;
            ae_used = ae_sh;
        end
        else
        begin
            af_used = af_sh;
            ae_used = ae_sh;
            if (cfg.wen && cfg.sel == SEL_AF_TH)
                af_sh = expected_clamp(int'(cfg.data));
            else if (cfg.wen)
                ae_sh = expected_clamp(int'(cfg.data));
            wr_ok = fifo_wen && model_q.size() < FIFO_DEPTH;
            rd_ok = fifo_ren && model_q.size() > 0;
            if (rd_ok)
                void'(model_q.pop_front());
            if (wr_ok)
                model_q.push_back(fifo_din);
        end
    end

    // status and head word checked every cycle while outputs are stable
    always @(negedge clk)
    begin
        if (chk_en)
        begin
            compare("data_cnt", 32'(model_q.size()), 32'(status.data_cnt));
            compare("full", 32'(model_q.size() == FIFO_DEPTH), 32'(status.full));
            compare("full_n", 32'(model_q.size() != FIFO_DEPTH), 32'(status.full_n));
            compare("almost_full", 32'(model_q.size() >= int'(af_used)), 32'(status.almost_full));
            compare("almost_empty", 32'(model_q.size() <= int'(ae_used)),
                    32'(status.almost_empty));
            if (!status.empty && model_q.size() == 0)
            begin
                $display("%s: empty is low although no word is stored", cur_test);
                test_errs++;
            end
            else if (!status.empty)
                compare("fifo_dout", model_q[0], fifo_dout);
        end
    end

    task automatic strobe(input logic wen, input logic ren);
        @(posedge clk);
        fifo_wen <= wen;
        fifo_din <= $random(seed);
        fifo_ren <= ren;
    endtask

    // one strobe then an idle cycle with reads only while a word is visible
    task automatic gapped_step(input logic wen, input logic want_rd);
        @(negedge clk);
        strobe(wen, want_rd && !status.empty);
        strobe(1'b0, 1'b0);
    endtask

    task automatic write_cfg(input thresh_sel_e sel, input int val);
        @(posedge clk);
        cfg.wen  <= 1'b1;
        cfg.sel  <= sel;
        cfg.data <= CNT_W'(val);
        @(posedge clk);
        cfg.wen <= 1'b0;
        @(negedge clk);
        compare("cfg_rdata", 32'(expected_clamp(val)), 32'(cfg_rdata));
    endtask

    task automatic finish_test();
        @(posedge clk);  // let this cycle's checks land first
        if (DUT.u_assertions.err_cnt != assert_seen)
        begin
            $display("%s: bound assertions failed %0d times", cur_test,
                     DUT.u_assertions.err_cnt - assert_seen);
            test_errs += DUT.u_assertions.err_cnt - assert_seen;
            assert_seen = DUT.u_assertions.err_cnt;
        end
        if (test_errs == 0)
        begin
            $display("PASS %s", cur_test);
            pass_cnt++;
        end
        else
        begin
            $display("FAIL %s with %0d errors", cur_test, test_errs);
            fail_cnt++;
        end
        test_errs = 0;
    endtask

    initial
    begin
        arst_n   = 1'b0;
        fifo_wen = 1'b0;
        fifo_din = '0;
        fifo_ren = 1'b0;
        cfg      = '0;
        chk_en   = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        chk_en = 1'b1;

        cur_test = "reset_state";
        @(negedge clk);
        compare("empty", 32'(1), 32'(status.empty));
        @(posedge clk);
        cfg.sel <= SEL_AF_TH;
        @(negedge clk);
        compare("af readback", 32'(AF_TH_RST), 32'(cfg_rdata));
        @(posedge clk);
        cfg.sel <= SEL_AE_TH;
        @(negedge clk);
        compare("ae readback", 32'(AE_TH_RST), 32'(cfg_rdata));
        finish_test();

        cur_test = "fwft_latency";
        strobe(1'b1, 1'b0);
        strobe(1'b0, 1'b0);  // this edge takes the write
        @(negedge clk);
        compare("empty at write edge", 32'(1), 32'(status.empty));
        @(negedge clk);
        compare("empty one cycle on", 32'(1), 32'(status.empty));
        @(negedge clk);
        compare("empty two cycles on", 32'(0), 32'(status.empty));
        strobe(1'b0, 1'b1);
        strobe(1'b0, 1'b0);
        @(negedge clk);
        compare("empty after read", 32'(1), 32'(status.empty));
        finish_test();

        cur_test = "fill_and_drain";
        repeat (FIFO_DEPTH + 1) strobe(1'b1, 1'b0);  // last one meets a full FIFO
        strobe(1'b0, 1'b0);
        @(negedge clk);
        compare("full after fill", 32'(1), 32'(status.full));
        for (int i = 0; i < FIFO_DEPTH; i++)
        begin
            strobe(1'b0, 1'b1);
            @(negedge clk);
            compare("empty during drain", 32'(0), 32'(status.empty));
        end
        strobe(1'b0, 1'b0);
        @(negedge clk);
        compare("empty after drain", 32'(1), 32'(status.empty));
        strobe(1'b0, 1'b1);
        strobe(1'b0, 1'b0);
        @(negedge clk);
        compare("empty after read while empty", 32'(1), 32'(status.empty));
        finish_test();

        cur_test = "mixed_read_write";
        for (int i = 0; i < N_MIXED; i++)
            gapped_step(1'($random(seed)), 1'($random(seed)));
        while (model_q.size() > 0)
            gapped_step(1'b0, 1'b1);
        finish_test();

        cur_test = "thresholds";
        write_cfg(SEL_AF_TH, 0);
        write_cfg(SEL_AF_TH, 20);
        write_cfg(SEL_AE_TH, 0);
        write_cfg(SEL_AE_TH, 20);
        write_cfg(SEL_AF_TH, 10);
        write_cfg(SEL_AE_TH, 4);
        repeat (FIFO_DEPTH) strobe(1'b1, 1'b0);  // crosses both thresholds
        strobe(1'b0, 1'b0);
        while (model_q.size() > 0)
            gapped_step(1'b0, 1'b1);
        finish_test();

        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
